// ==== design/wro_buffer_and_hash.sv ====
// WRO pipeline head: buffers client requests, hashes addresses and holds the oldest pair
module wro_buffer_and_hash
#(
    parameter int HASH_BITS = 9,
    parameter int BUF_THRESHOLD = 8
)
(
    input  logic                 clk,
    input  logic                 reset,

    // Client request strobes, one program step per cycle
    input  wro_pkg::wro_rd_req_t client_rd,
    input  wro_pkg::wro_wr_req_t client_wr,
    output logic                 client_almost_full,

    // Output stage, valids masked while blocked
    output wro_pkg::wro_rd_req_t head_rd,
    output wro_pkg::wro_wr_req_t head_wr,

    // Index 0 is the held request and index 1 the next one at the FIFO head
    output logic [HASH_BITS-1:0] rd_hash [0:1],
    output logic [HASH_BITS-1:0] wr_hash [0:1],
    input  logic                 rd_conflict [0:1],
    input  logic                 wr_conflict [0:1],

    // Held request has gone to memory
    input  logic                 rd_deq,
    input  logic                 wr_deq,

    // Idle indications, used for write fences
    input  logic                 pipe_not_empty,
    output logic                 buf_not_empty
);

    import wro_pkg::*;

    // Extra room above the threshold absorbs the client's stop latency
    localparam int BUF_ENTRIES = BUF_THRESHOLD + (BUF_THRESHOLD / 2);

    typedef logic [HASH_BITS-1:0] hash_t;

    // ====================
    // Input stage
    // ====================

    wro_rd_req_t in_rd;
    wro_wr_req_t in_wr;
    hash_t       in_rd_hash;
    hash_t       in_wr_hash;
    logic        step_en;

    // The hash costs a cycle, so the request is registered beside it
    always_ff @(posedge clk)
    begin
        in_rd <= client_rd;
        in_wr <= client_wr;
        in_rd_hash <= hash_t'(wro_hash32(client_rd.addr));
        in_wr_hash <= hash_t'(wro_hash32(client_wr.addr));

        if (reset)
        begin
            in_rd.valid <= 1'b0;
            in_wr.valid <= 1'b0;
        end
    end

    // Both request FIFOs move in lockstep so that one entry is one program step
    assign step_en = in_rd.valid || in_wr.valid;

    // ====================
    // Buffers
    // ====================

    wro_rd_req_t fifo_rd;
    wro_wr_req_t fifo_wr;
    hash_t       rd_hash_fifo;
    hash_t       wr_hash_fifo;
    logic        rd_req_not_empty;
    logic        wr_req_not_empty;
    logic        rd_hash_not_empty;
    logic        wr_hash_not_empty;
    logic        rd_almost_full;
    logic        wr_almost_full;
    logic        fifo_deq;

    wro_fifo #(.payload_t(wro_rd_req_t), .N_ENTRIES(BUF_ENTRIES), .THRESHOLD(BUF_THRESHOLD))
    i_rd_req_buf
    (
        .clk, .reset,
        .enq_data(in_rd), .enq_en(step_en), .deq_en(fifo_deq),
        .first(fifo_rd), .not_empty(rd_req_not_empty), .almost_full(rd_almost_full)
    );

    wro_fifo #(.payload_t(wro_wr_req_t), .N_ENTRIES(BUF_ENTRIES), .THRESHOLD(BUF_THRESHOLD))
    i_wr_req_buf
    (
        .clk, .reset,
        .enq_data(in_wr), .enq_en(step_en), .deq_en(fifo_deq),
        .first(fifo_wr), .not_empty(wr_req_not_empty), .almost_full(wr_almost_full)
    );

    // Hashes are queued only for valid requests, like a sparse side channel
    wro_fifo #(.payload_t(hash_t), .N_ENTRIES(BUF_ENTRIES), .THRESHOLD(BUF_THRESHOLD))
    i_rd_hash_buf
    (
        .clk, .reset,
        .enq_data(in_rd_hash), .enq_en(in_rd.valid), .deq_en(fifo_deq && fifo_rd.valid),
        .first(rd_hash_fifo), .not_empty(rd_hash_not_empty), .almost_full()
    );

    wro_fifo #(.payload_t(hash_t), .N_ENTRIES(BUF_ENTRIES), .THRESHOLD(BUF_THRESHOLD))
    i_wr_hash_buf
    (
        .clk, .reset,
        .enq_data(in_wr_hash), .enq_en(in_wr.valid), .deq_en(fifo_deq && fifo_wr.valid),
        .first(wr_hash_fifo), .not_empty(wr_hash_not_empty), .almost_full()
    );

    assign client_almost_full = rd_almost_full || wr_almost_full;

    // ====================
    // Output stage
    // ====================

    wro_rd_req_t held_rd;
    wro_wr_req_t held_wr;
    hash_t       held_rd_hash;
    hash_t       held_wr_hash;
    logic        rd_block;
    logic        wr_block;
    logic        tx_addr_conflict;
    logic        fifo_ready;
    logic        fifo_addr_conflict;
    logic        block_for_fence;

    // A step is ready once its hashes have landed beside it
    assign fifo_ready = rd_req_not_empty && wr_req_not_empty &&
                        (!fifo_rd.valid || rd_hash_not_empty) &&
                        (!fifo_wr.valid || wr_hash_not_empty);

    // Advance when both held slots are free or leaving this cycle
    assign fifo_deq = (rd_deq || !held_rd.valid) && (wr_deq || !held_wr.valid) && fifo_ready;

    // Read and write of the same step touching the same line
    assign fifo_addr_conflict = fifo_rd.valid && fifo_wr.valid &&
                                (rd_hash_fifo == wr_hash_fifo);

    // A fence waits for the filter and for the read of its own step
    assign block_for_fence = held_wr.valid && held_wr.fence &&
                             (pipe_not_empty || held_rd.valid);

    always_ff @(posedge clk)
    begin
        if (rd_deq)
        begin
            held_rd.valid <= 1'b0;
            // The write of this step may now follow its read
            tx_addr_conflict <= 1'b0;
        end

        if (wr_deq)
        begin
            held_wr.valid <= 1'b0;
        end

        // Waiting requests are retested against the filter every cycle
        rd_block <= rd_conflict[0];
        wr_block <= wr_conflict[0] || tx_addr_conflict || block_for_fence;

        if (fifo_deq)
        begin
            held_rd <= fifo_rd;
            held_wr <= fifo_wr;
            if (fifo_rd.valid)
            begin
                held_rd_hash <= rd_hash_fifo;
            end
            if (fifo_wr.valid)
            begin
                held_wr_hash <= wr_hash_fifo;
            end

            tx_addr_conflict <= fifo_addr_conflict;

            // The filter has not yet recorded what leaves on this edge,
            // so new requests are also checked against the released hashes
            rd_block <= rd_conflict[1] || (held_wr_hash == rd_hash_fifo);
            wr_block <= wr_conflict[1] ||
                        (held_rd_hash == wr_hash_fifo) ||
                        (held_wr_hash == wr_hash_fifo) ||
                        fifo_addr_conflict ||
                        fifo_wr.fence;
        end

        if (reset)
        begin
            held_rd.valid <= 1'b0;
            held_wr.valid <= 1'b0;
            held_rd_hash <= '0;
            held_wr_hash <= '0;
            rd_block <= 1'b0;
            wr_block <= 1'b0;
            tx_addr_conflict <= 1'b0;
        end
    end

    // Blocked requests are hidden from the filter
    always_comb
    begin
        head_rd = held_rd;
        head_rd.valid = held_rd.valid && !rd_block;
        head_wr = held_wr;
        head_wr.valid = held_wr.valid && !wr_block;
    end

    assign rd_hash[0] = held_rd_hash;
    assign rd_hash[1] = rd_hash_fifo;
    assign wr_hash[0] = held_wr_hash;
    assign wr_hash[1] = wr_hash_fifo;

    // Anything still inside this block, from the input register to the held pair
    assign buf_not_empty = step_en || rd_req_not_empty || wr_req_not_empty ||
                           held_rd.valid || held_wr.valid;

endmodule

// ==== design/wro_fifo.sv ====
// Synchronous FIFO with a typed payload, registered head entry and occupancy flags
module wro_fifo
#(
    parameter type payload_t = logic,
    parameter int N_ENTRIES = 12,
    parameter int THRESHOLD = 8
)
(
    input  logic     clk,
    input  logic     reset,
    input  payload_t enq_data,
    input  logic     enq_en,
    input  logic     deq_en,
    output payload_t first,
    output logic     not_empty,
    output logic     almost_full
);

    localparam int PTR_BITS = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [CNT_BITS-1:0] cnt_t;

    payload_t mem [N_ENTRIES];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    ptr_t     rd_ptr_next;
    cnt_t     count;
    logic     do_enq;
    logic     do_deq;

    // Circular pointer step
    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(N_ENTRIES - 1)) ? '0 : p + 1'b1;
    endfunction

    // Requests on an empty or full FIFO are ignored
    // The producer honors almost_full, so the full case never drops data
    assign do_deq = deq_en && (count != '0);
    assign do_enq = enq_en && (count != cnt_t'(N_ENTRIES));

    assign rd_ptr_next = do_deq ? ptr_inc(rd_ptr) : rd_ptr;

    assign not_empty = (count != '0);

    // The entry being written this cycle already counts toward the level
    assign almost_full = (int'(count) + int'(enq_en)) >= THRESHOLD;

    always_ff @(posedge clk)
    begin
        if (do_enq)
        begin
            mem[wr_ptr] <= enq_data;
            wr_ptr <= ptr_inc(wr_ptr);
        end

        rd_ptr <= rd_ptr_next;
        count <= count + cnt_t'(do_enq) - cnt_t'(do_deq);

        // The head register takes the incoming entry when nothing older remains
        if (do_enq && (count == cnt_t'(do_deq)))
        begin
            first <= enq_data;
        end
        else
        begin
            first <= mem[rd_ptr_next];
        end

        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
    end

endmodule

// ==== design/wro_inflight_filter.sv ====
// WRO in-flight filter: tracks hashes of issued requests by tag and issues to memory
module wro_inflight_filter
#(
    parameter int HASH_BITS = 9
)
(
    input  logic                 clk,
    input  logic                 reset,

    // Output stage of the buffer head
    input  wro_pkg::wro_rd_req_t head_rd,
    input  wro_pkg::wro_wr_req_t head_wr,
    input  logic [HASH_BITS-1:0] rd_hash [0:1],
    input  logic [HASH_BITS-1:0] wr_hash [0:1],
    output logic                 rd_conflict [0:1],
    output logic                 wr_conflict [0:1],
    output logic                 rd_deq,
    output logic                 wr_deq,
    output logic                 pipe_not_empty,

    // Memory port
    input  logic                 mem_almost_full,
    output wro_pkg::wro_rd_req_t mem_rd,
    output wro_pkg::wro_wr_req_t mem_wr,
    input  logic                 mem_rd_done_valid,
    input  wro_pkg::wro_tag_t    mem_rd_done_tag,
    input  logic                 mem_wr_done_valid,
    input  wro_pkg::wro_tag_t    mem_wr_done_tag
);

    import wro_pkg::*;

    localparam int N_TAGS = 1 << TAG_BITS;

    typedef logic [HASH_BITS-1:0] hash_t;

    // One entry per tag and channel
    logic [N_TAGS-1:0] rd_live;
    logic [N_TAGS-1:0] wr_live;
    hash_t             rd_tbl [N_TAGS];
    hash_t             wr_tbl [N_TAGS];

    // ====================
    // Conflict check
    // ====================

    // Reads only need to wait for writes
    // Writes wait for both reads and writes to the same line
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            rd_conflict[i] = 1'b0;
            wr_conflict[i] = 1'b0;
            for (int t = 0; t < N_TAGS; t++)
            begin
                if (wr_live[t] && (wr_tbl[t] == rd_hash[i]))
                begin
                    rd_conflict[i] = 1'b1;
                end
                if (wr_live[t] && (wr_tbl[t] == wr_hash[i]))
                begin
                    wr_conflict[i] = 1'b1;
                end
                if (rd_live[t] && (rd_tbl[t] == wr_hash[i]))
                begin
                    wr_conflict[i] = 1'b1;
                end
            end
        end
    end

    // ====================
    // Issue and completion
    // ====================

    // Head valids are already masked by the buffer, so only memory backpressure stalls
    assign rd_deq = head_rd.valid && !mem_almost_full;
    assign wr_deq = head_wr.valid && !mem_almost_full;

    // A request leaving this cycle is not in the table yet but counts as busy
    assign pipe_not_empty = (|rd_live) || (|wr_live) || rd_deq || wr_deq;

    always_ff @(posedge clk)
    begin
        mem_rd <= head_rd;
        mem_rd.valid <= rd_deq;
        mem_wr <= head_wr;
        mem_wr.valid <= wr_deq;

        // Completions free the tag's entry
        if (mem_rd_done_valid)
        begin
            rd_live[mem_rd_done_tag] <= 1'b0;
        end
        if (mem_wr_done_valid)
        begin
            wr_live[mem_wr_done_tag] <= 1'b0;
        end

        // Record the hash as the request leaves for memory
        if (rd_deq)
        begin
            rd_live[head_rd.tag] <= 1'b1;
            rd_tbl[head_rd.tag] <= rd_hash[0];
        end
        if (wr_deq)
        begin
            wr_live[head_wr.tag] <= 1'b1;
            wr_tbl[head_wr.tag] <= wr_hash[0];
        end

        if (reset)
        begin
            rd_live <= '0;
            wr_live <= '0;
            mem_rd.valid <= 1'b0;
            mem_wr.valid <= 1'b0;
        end
    end

endmodule

// ==== design/wro_pkg.sv ====
// WRO shared types: request structs, widths and the address hash function
package wro_pkg;

    // ====================
    // Widths
    // ====================

    // Tag width sets the number of in-flight requests per channel
    localparam int TAG_BITS = 4;

    // Modules truncate the folded hash to their own HASH_BITS
    localparam int HASH_BITS_MAX = 32;

    typedef logic [31:0] wro_addr_t;
    typedef logic [31:0] wro_data_t;
    typedef logic [TAG_BITS-1:0] wro_tag_t;

    // ====================
    // Requests
    // ====================

    // Read request on channel 0
    typedef struct packed {
        logic      valid;
        wro_tag_t  tag;
        wro_addr_t addr;
    } wro_rd_req_t;

    // Write request on channel 1
    // A fence is a normal write that also waits for an idle pipeline
    typedef struct packed {
        logic      valid;
        logic      fence;
        wro_tag_t  tag;
        wro_addr_t addr;
        wro_data_t data;
    } wro_wr_req_t;

    // ====================
    // Hash
    // ====================

    // Rotate and xor mix of the line address
    // Collisions are harmless and only cost a stall, so the mix stays cheap
    function automatic logic [HASH_BITS_MAX-1:0] wro_hash32(wro_addr_t addr);
        logic [31:0] h;

        h = addr;
        h = h ^ {h[18:0], h[31:19]};
        h = h ^ {h[6:0], h[31:7]};
        h = h ^ {h[24:0], h[31:25]};
        // Fold the upper half down so that low bits see every address bit
        h = h ^ {h[15:0], h[31:16]};
        return h;
    endfunction

endpackage

// ==== design/wro_top.sv ====
// WRO shim top level: connects the buffer head to the in-flight filter
module wro_top
#(
    parameter int HASH_BITS = 9,
    parameter int BUF_THRESHOLD = 8
)
(
    input  logic                 clk,
    input  logic                 reset,

    // Client side
    input  wro_pkg::wro_rd_req_t client_rd,
    input  wro_pkg::wro_wr_req_t client_wr,
    output logic                 client_almost_full,
    output logic                 buf_not_empty,
    output logic                 rsp_rd_valid,
    output wro_pkg::wro_tag_t    rsp_rd_tag,
    output wro_pkg::wro_data_t   rsp_rd_data,
    output logic                 rsp_wr_valid,
    output wro_pkg::wro_tag_t    rsp_wr_tag,

    // Memory side
    input  logic                 mem_almost_full,
    output wro_pkg::wro_rd_req_t mem_rd,
    output wro_pkg::wro_wr_req_t mem_wr,
    input  logic                 mem_rd_done_valid,
    input  wro_pkg::wro_tag_t    mem_rd_done_tag,
    input  wro_pkg::wro_data_t   mem_rd_done_data,
    input  logic                 mem_wr_done_valid,
    input  wro_pkg::wro_tag_t    mem_wr_done_tag
);

    import wro_pkg::*;

    wro_rd_req_t          head_rd;
    wro_wr_req_t          head_wr;
    logic [HASH_BITS-1:0] rd_hash [0:1];
    logic [HASH_BITS-1:0] wr_hash [0:1];
    logic                 rd_conflict [0:1];
    logic                 wr_conflict [0:1];
    logic                 rd_deq;
    logic                 wr_deq;
    logic                 pipe_not_empty;

    wro_buffer_and_hash #(.HASH_BITS(HASH_BITS), .BUF_THRESHOLD(BUF_THRESHOLD))
    i_buffer_and_hash
    (
        .clk, .reset,
        .client_rd, .client_wr, .client_almost_full,
        .head_rd, .head_wr,
        .rd_hash, .wr_hash, .rd_conflict, .wr_conflict,
        .rd_deq, .wr_deq,
        .pipe_not_empty, .buf_not_empty
    );

    wro_inflight_filter #(.HASH_BITS(HASH_BITS))
    i_inflight_filter
    (
        .clk, .reset,
        .head_rd, .head_wr,
        .rd_hash, .wr_hash, .rd_conflict, .wr_conflict,
        .rd_deq, .wr_deq, .pipe_not_empty,
        .mem_almost_full, .mem_rd, .mem_wr,
        .mem_rd_done_valid, .mem_rd_done_tag,
        .mem_wr_done_valid, .mem_wr_done_tag
    );

    // Completions go straight back to the client
    assign rsp_rd_valid = mem_rd_done_valid;
    assign rsp_rd_tag = mem_rd_done_tag;
    assign rsp_rd_data = mem_rd_done_data;
    assign rsp_wr_valid = mem_wr_done_valid;
    assign rsp_wr_tag = mem_wr_done_tag;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the WRO testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module wro_tb -f wro_top.f

# The log decides the outcome, so a fatal exit of the model does not stop here
./obj_dir/Vwro_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation reported an error"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

// ==== tests/wro_tb.sv ====
// WRO shim testbench: random client program against a random-latency memory model
module wro_tb;

    import wro_pkg::*;

    localparam int HASH_BITS = 9;
    localparam int BUF_THRESHOLD = 8;
    localparam int N_STEPS = 400;
    localparam int N_ADDRS = 8;
    localparam int N_TAGS = 1 << TAG_BITS;
    localparam int CYCLE_LIMIT = N_STEPS * 40;

    // One program step as the client issued it, read ordered before write
    typedef struct packed {
        logic      rd_valid;
        wro_addr_t rd_addr;
        logic      wr_valid;
        wro_addr_t wr_addr;
        wro_data_t wr_data;
    } step_t;

    // Request accepted by the memory model and waiting for its completion
    typedef struct packed {
        wro_tag_t  tag;
        wro_data_t data;
        int        due;
    } pending_t;

    logic        clk;
    logic        reset;
    wro_rd_req_t client_rd;
    wro_wr_req_t client_wr;
    logic        client_almost_full;
    logic        buf_not_empty;
    logic        rsp_rd_valid;
    wro_tag_t    rsp_rd_tag;
    wro_data_t   rsp_rd_data;
    logic        rsp_wr_valid;
    wro_tag_t    rsp_wr_tag;
    logic        mem_almost_full;
    wro_rd_req_t mem_rd;
    wro_wr_req_t mem_wr;
    logic        mem_rd_done_valid;
    wro_tag_t    mem_rd_done_tag;
    wro_data_t   mem_rd_done_data;
    logic        mem_wr_done_valid;
    wro_tag_t    mem_wr_done_tag;

    step_t     program_steps [N_STEPS];
    wro_addr_t addr_pool [N_ADDRS];
    wro_data_t mem_model [wro_addr_t];
    pending_t  rd_pending [$];
    pending_t  wr_pending [$];
    int        rd_tag_step [N_TAGS];
    int        wr_tag_step [N_TAGS];
    logic      rd_tag_busy [N_TAGS];
    logic      wr_tag_busy [N_TAGS];
    int        n_steps = 0;
    int        rd_issued = 0;
    int        wr_issued = 0;
    int        mem_rd_cnt = 0;
    int        mem_wr_cnt = 0;
    int        rd_done_cnt = 0;
    int        wr_done_cnt = 0;
    int        error_count = 0;
    int        cycle_count = 0;
    bit        started = 1'b0;

    wro_top #(.HASH_BITS(HASH_BITS), .BUF_THRESHOLD(BUF_THRESHOLD))
    i_dut
    (
        .clk, .reset,
        .client_rd, .client_wr, .client_almost_full, .buf_not_empty,
        .rsp_rd_valid, .rsp_rd_tag, .rsp_rd_data, .rsp_wr_valid, .rsp_wr_tag,
        .mem_almost_full, .mem_rd, .mem_wr,
        .mem_rd_done_valid, .mem_rd_done_tag, .mem_rd_done_data,
        .mem_wr_done_valid, .mem_wr_done_tag
    );

    // ====================
    // Helpers
    // ====================

    // Report the first error and stop the run
    task automatic fail_run(string what);
        error_count++;
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Memory contents before any write, a mix of every address bit
    function automatic wro_data_t initial_value(wro_addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'hc3a5_0f1e;
    endfunction

    // Replays the program up to a read and returns the latest earlier write to its line
    function automatic wro_data_t expected_read(int step);
        wro_data_t value;

        value = initial_value(program_steps[step].rd_addr);
        for (int i = 0; i < step; i++)
        begin
            if (program_steps[i].wr_valid && (program_steps[i].wr_addr == program_steps[step].rd_addr))
            begin
                value = program_steps[i].wr_data;
            end
        end
        return value;
    endfunction

    // Random free tag of a channel, or -1 when all are in flight
    function automatic int free_tag(logic wr_channel);
        int start;
        int t;

        start = $urandom_range(N_TAGS - 1, 0);
        for (int i = 0; i < N_TAGS; i++)
        begin
            t = (start + i) % N_TAGS;
            if (wr_channel ? !wr_tag_busy[t] : !rd_tag_busy[t])
            begin
                return t;
            end
        end
        return -1;
    endfunction

    // Oldest pending entry whose latency has run out
    function automatic int first_due(pending_t q [$], int now);
        for (int i = 0; i < q.size(); i++)
        begin
            if (q[i].due <= now)
            begin
                return i;
            end
        end
        return -1;
    endfunction

    // Drives one program step, or leaves the cycle idle
    task automatic issue_step();
        int    kind;
        int    rtag;
        int    wtag;
        step_t s;

        kind = $urandom_range(3, 0);
        rtag = free_tag(1'b0);
        wtag = free_tag(1'b1);
        s = '0;
        // Kind 0 is a read, 1 a write, 2 both and 3 an idle cycle
        s.rd_valid = (kind == 0 || kind == 2) && (rtag >= 0);
        s.wr_valid = (kind == 1 || kind == 2) && (wtag >= 0);
        s.rd_addr = addr_pool[$urandom_range(N_ADDRS - 1, 0)];
        s.wr_addr = addr_pool[$urandom_range(N_ADDRS - 1, 0)];
        s.wr_data = $urandom();
        if (s.rd_valid)
        begin
            client_rd = '{valid: 1'b1, tag: wro_tag_t'(rtag), addr: s.rd_addr};
            rd_tag_busy[rtag] = 1'b1;
            rd_tag_step[rtag] = n_steps;
            rd_issued++;
        end
        if (s.wr_valid)
        begin
            client_wr.valid = 1'b1;
            client_wr.fence = ($urandom_range(15, 0) == 0);
            client_wr.tag = wro_tag_t'(wtag);
            client_wr.addr = s.wr_addr;
            client_wr.data = s.wr_data;
            wr_tag_busy[wtag] = 1'b1;
            wr_tag_step[wtag] = n_steps;
            wr_issued++;
        end
        if (s.rd_valid || s.wr_valid)
        begin
            program_steps[n_steps] = s;
            n_steps++;
        end
    endtask

    // ====================
    // Clock and timeout
    // ====================

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        forever
        begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= CYCLE_LIMIT)
            begin
                fail_run("Timeout: the run did not finish within the cycle limit");
            end
        end
    end

    // ====================
    // Memory model
    // ====================

    initial
    begin
        int       now;
        int       idx;
        logic     maf_d1;
        pending_t p;

        now = 0;
        maf_d1 = 1'b0;
        mem_rd_done_valid = 1'b0;
        mem_rd_done_tag = '0;
        mem_rd_done_data = '0;
        mem_wr_done_valid = 1'b0;
        mem_wr_done_tag = '0;
        forever
        begin
            @(posedge clk);
            now++;
            if (!reset)
            begin
                // Strobes seen at this edge were decided while maf_d1 was applied
                assert (!(maf_d1 && (mem_rd.valid || mem_wr.valid)))
                else fail_run("A memory request was issued while mem_almost_full was high");
                if (mem_wr.valid && mem_wr.fence)
                begin
                    assert ((rd_pending.size() == 0) && (wr_pending.size() == 0) && !mem_rd.valid)
                    else fail_run("A fence write reached memory while requests were outstanding");
                end
                // Reads see memory before a write of the same edge
                if (mem_rd.valid)
                begin
                    assert (mem_rd.addr == program_steps[rd_tag_step[mem_rd.tag]].rd_addr)
                    else fail_run($sformatf("FAIL: mem_rd.addr exp %h got %h",
                        program_steps[rd_tag_step[mem_rd.tag]].rd_addr, mem_rd.addr));
                    p = '{tag: mem_rd.tag, data: mem_model[mem_rd.addr], due: now};
                    p.due = now + int'($urandom_range(12, 1));
                    rd_pending.push_back(p);
                    mem_rd_cnt++;
                end
                if (mem_wr.valid)
                begin
                    assert (mem_wr.addr == program_steps[wr_tag_step[mem_wr.tag]].wr_addr)
                    else fail_run($sformatf("FAIL: mem_wr.addr exp %h got %h",
                        program_steps[wr_tag_step[mem_wr.tag]].wr_addr, mem_wr.addr));
                    assert (mem_wr.data == program_steps[wr_tag_step[mem_wr.tag]].wr_data)
                    else fail_run($sformatf("FAIL: mem_wr.data exp %h got %h",
                        program_steps[wr_tag_step[mem_wr.tag]].wr_data, mem_wr.data));
                    mem_model[mem_wr.addr] = mem_wr.data;
                    p = '{tag: mem_wr.tag, data: mem_wr.data, due: now};
                    p.due = now + int'($urandom_range(12, 1));
                    wr_pending.push_back(p);
                    mem_wr_cnt++;
                end
            end
            maf_d1 = mem_almost_full;

            #1;
            mem_rd_done_valid = 1'b0;
            mem_wr_done_valid = 1'b0;
            idx = first_due(rd_pending, now);
            if (idx >= 0)
            begin
                mem_rd_done_valid = 1'b1;
                mem_rd_done_tag = rd_pending[idx].tag;
                mem_rd_done_data = rd_pending[idx].data;
                rd_pending.delete(idx);
            end
            idx = first_due(wr_pending, now);
            if (idx >= 0)
            begin
                mem_wr_done_valid = 1'b1;
                mem_wr_done_tag = wr_pending[idx].tag;
                wr_pending.delete(idx);
            end
        end
    end

    // Memory stalls long enough to fill the request buffers
    initial
    begin
        bit saw_full;

        mem_almost_full = 1'b0;
        wait (started);
        while (n_steps < N_STEPS)
        begin
            repeat ($urandom_range(200, 60)) @(posedge clk);
            #1 mem_almost_full = 1'b1;
            saw_full = 1'b0;
            repeat (40)
            begin
                @(posedge clk);
                #2;
                saw_full = saw_full || client_almost_full;
            end
            @(posedge clk);
            #1 mem_almost_full = 1'b0;
            // A client with steps left must have been throttled
            if (n_steps < N_STEPS)
            begin
                assert (saw_full)
                else fail_run("client_almost_full never rose while memory was stalled");
            end
        end
    end

    // ====================
    // Comparison
    // ====================

    always @(posedge clk)
    begin
        if (!reset && rsp_rd_valid)
        begin
            assert (rd_tag_busy[rsp_rd_tag])
            else fail_run("A read completed on a tag with no request in flight");
            assert (rsp_rd_data == expected_read(rd_tag_step[rsp_rd_tag]))
            else fail_run($sformatf("FAIL: rsp_rd_data tag %h exp %h got %h", rsp_rd_tag,
                expected_read(rd_tag_step[rsp_rd_tag]), rsp_rd_data));
            rd_tag_busy[rsp_rd_tag] = 1'b0;
            rd_done_cnt++;
        end
        if (!reset && rsp_wr_valid)
        begin
            assert (wr_tag_busy[rsp_wr_tag])
            else fail_run("A write completed on a tag with no request in flight");
            wr_tag_busy[rsp_wr_tag] = 1'b0;
            wr_done_cnt++;
        end
    end

    // ====================
    // Client program
    // ====================

    initial
    begin
        void'($urandom(32'h9ebe32ff));
        reset = 1'b1;
        client_rd = '0;
        client_wr = '0;
        for (int i = 0; i < N_ADDRS; i++)
        begin
            addr_pool[i] = wro_addr_t'(32'h1000_0000 + (i * 32'h0001_0040));
            mem_model[addr_pool[i]] = initial_value(addr_pool[i]);
        end
        for (int t = 0; t < N_TAGS; t++)
        begin
            rd_tag_busy[t] = 1'b0;
            wr_tag_busy[t] = 1'b0;
            rd_tag_step[t] = 0;
            wr_tag_step[t] = 0;
        end

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        started = 1'b1;
        assert (!client_almost_full && !mem_rd.valid && !mem_wr.valid && !i_dut.pipe_not_empty)
        else fail_run("Outputs were not idle after reset");

        while (n_steps < N_STEPS)
        begin
            @(posedge clk);
            #1;
            client_rd = '0;
            client_wr = '0;
            if (!client_almost_full)
            begin
                issue_step();
            end
        end
        @(posedge clk);
        #1;
        client_rd = '0;
        client_wr = '0;

        // Every request drains through memory before the final checks
        while ((rd_done_cnt != rd_issued) || (wr_done_cnt != wr_issued))
        begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;

        assert (mem_rd_cnt == rd_issued)
        else fail_run($sformatf("FAIL: mem_rd count exp %h got %h", rd_issued, mem_rd_cnt));
        assert (mem_wr_cnt == wr_issued)
        else fail_run($sformatf("FAIL: mem_wr count exp %h got %h", wr_issued, mem_wr_cnt));
        assert (!buf_not_empty)
        else fail_run($sformatf("FAIL: buf_not_empty exp %h got %h", 1'b0, buf_not_empty));
        assert (!i_dut.pipe_not_empty)
        else fail_run($sformatf("FAIL: pipe_not_empty exp %h got %h", 1'b0,
            i_dut.pipe_not_empty));

        if (error_count == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== wro_top.f ====
design/wro_pkg.sv
design/wro_fifo.sv
design/wro_buffer_and_hash.sv
design/wro_inflight_filter.sv
design/wro_top.sv
tests/wro_tb.sv
